/* lsq_cfg.svh */
`ifndef LSQ_CFG_SVH
`define LSQ_CFG_SVH

// Address and data width
`define XLEN 32

// Store queue depth, kept a power of two so indices wrap on their own
`define SQ_LEN 8
`define SQ_IDX_BITS 3

// Stores dispatched per cycle from decode
`define N 2

// Backing memory depth in words
`define MEM_WORDS 64
`define MEM_IDX_BITS 6

`endif

/* lsq_pkg.sv */
`include "lsq_cfg.svh"

package lsq_pkg;

    typedef logic [`XLEN-1:0] addr_t;
    typedef logic [`XLEN-1:0] data_t;
    typedef logic [`SQ_IDX_BITS-1:0] sq_idx_t;
    typedef logic [`SQ_IDX_BITS:0] sq_cnt_t;

    // RISC-V funct3, bit 2 is unsigned, bits 1:0 the size
    typedef logic [2:0] mem_func_t;
    typedef logic [3:0] byte_en_t;

    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;

    // Decode allocation slot
    typedef struct packed {
        logic      valid;
        mem_func_t func;
    } id_sq_t;

    // Store unit result, address still split as base plus offset
    typedef struct packed {
        logic        valid;
        addr_t       base;
        logic [11:0] offset;
        data_t       data;
        sq_idx_t     sq_idx;
    } rs_sq_t;

    typedef struct packed {
        logic      valid;
        logic      ready;
        mem_func_t func;
        addr_t     addr;
        data_t     data;
    } sq_entry_t;

    // Data is already replicated across the enabled lanes
    typedef struct packed {
        logic     valid;
        addr_t    addr;
        data_t    data;
        byte_en_t byte_en;
    } store_req_t;

    typedef struct packed {
        logic      valid;
        addr_t     addr;
        mem_func_t func;
        sq_idx_t   tail_store;
    } load_req_t;

    typedef struct packed {
        byte_en_t byte_valid;
        data_t    data;
    } fwd_t;

    typedef struct packed {
        logic  valid;
        data_t data;
    } load_rsp_t;

endpackage

/* store_queue.sv */
`include "lsq_cfg.svh"

module store_queue
    import lsq_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  id_sq_t [`N-1:0]     id_sq,
    input  rs_sq_t              rs_sq,
    input  sq_cnt_t             commit_count,
    input  load_req_t           load_req,
    output logic                almost_full,
    output sq_idx_t             tail,
    output sq_idx_t             tail_ready,
    output store_req_t          store_req,
    output fwd_t                fwd
);

    // Byte lanes touched by an access of the given size at the given offset
    function automatic byte_en_t lanes_of(input logic [1:0] offset, input logic [1:0] size);
        byte_en_t lanes;
        case (size)
            SIZE_BYTE: lanes = 4'b0001 << offset;
            SIZE_HALF: lanes = 4'b0011 << {offset[1], 1'b0};
            default:   lanes = 4'b1111;
        endcase
        return lanes;
    endfunction

    // Copy the low bytes into every lane so any lane can be picked
    function automatic data_t replicate(input data_t data, input logic [1:0] size);
        data_t word;
        case (size)
            SIZE_BYTE: word = {4{data[7:0]}};
            SIZE_HALF: word = {2{data[15:0]}};
            default:   word = data;
        endcase
        return word;
    endfunction

    sq_entry_t [`SQ_LEN-1:0] entries;
    sq_entry_t [`SQ_LEN-1:0] next_entries;

    sq_idx_t head;
    sq_idx_t next_head;
    sq_idx_t next_tail;
    sq_cnt_t count;
    sq_cnt_t next_count;
    sq_cnt_t pending;
    sq_cnt_t next_pending;

    // Store unit result, held one cycle before it lands in the entry
    logic    fill_valid;
    sq_idx_t fill_idx;
    addr_t   fill_addr;
    data_t   fill_data;

    sq_entry_t head_entry;
    logic      drain;

    sq_idx_t scan_idx;
    sq_cnt_t ready_run;
    logic    run_open;

    sq_idx_t  fwd_idx;
    byte_en_t fwd_lanes;
    data_t    fwd_word;
    sq_cnt_t  load_older;

    assign almost_full = count > sq_cnt_t'(`SQ_LEN - `N);

    // Drain port to memory
    assign head_entry = entries[head];
    assign drain = head_entry.valid && head_entry.ready && (pending != '0);

    assign store_req.valid   = drain;
    assign store_req.addr    = head_entry.addr;
    assign store_req.data    = replicate(head_entry.data, head_entry.func[1:0]);
    assign store_req.byte_en = lanes_of(head_entry.addr[1:0], head_entry.func[1:0]);

    always_comb begin
        next_entries = entries;
        next_head    = head;
        next_tail    = tail;
        next_count   = count;
        next_pending = pending + commit_count;

        if (drain) begin
            next_entries[head].valid = 1'b0;
            next_entries[head].ready = 1'b0;
            next_head    = head + 1'b1;
            next_count   = next_count - 1'b1;
            next_pending = next_pending - 1'b1;
        end

        // Allocate in slot order at the tail
        if (!almost_full) begin
            for (int i = 0; i < `N; i++) begin
                if (id_sq[i].valid) begin
                    next_entries[next_tail].valid = 1'b1;
                    next_entries[next_tail].ready = 1'b0;
                    next_entries[next_tail].func  = id_sq[i].func;
                    next_tail  = next_tail + 1'b1;
                    next_count = next_count + 1'b1;
                end
            end
        end

        if (fill_valid) begin
            next_entries[fill_idx].ready = 1'b1;
            next_entries[fill_idx].addr  = fill_addr;
            next_entries[fill_idx].data  = fill_data;
        end
    end

    // Length of the oldest run of ready entries
    always_comb begin
        ready_run = '0;
        run_open  = 1'b1;
        for (int i = 0; i < `SQ_LEN; i++) begin
            scan_idx = head + sq_idx_t'(i);
            if (run_open && entries[scan_idx].valid && entries[scan_idx].ready) begin
                ready_run = ready_run + 1'b1;
            end else begin
                run_open = 1'b0;
            end
        end
        tail_ready = head + ready_run[`SQ_IDX_BITS-1:0];
    end

    // Stores older than the load; a snapshot equal to tail means all of them
    assign load_older = (load_req.tail_store == tail) ? count
                                                      : {1'b0, load_req.tail_store - head};

    // Oldest to youngest, so a younger match overwrites per byte
    always_comb begin
        fwd = '0;
        for (int j = 0; j < `SQ_LEN; j++) begin
            fwd_idx   = head + sq_idx_t'(j);
            fwd_lanes = lanes_of(entries[fwd_idx].addr[1:0], entries[fwd_idx].func[1:0]);
            fwd_word  = replicate(entries[fwd_idx].data, entries[fwd_idx].func[1:0]);
            if (load_req.valid && sq_cnt_t'(j) < load_older
                && entries[fwd_idx].valid && entries[fwd_idx].ready
                && entries[fwd_idx].addr[`XLEN-1:2] == load_req.addr[`XLEN-1:2]) begin
                for (int b = 0; b < 4; b++) begin
                    if (fwd_lanes[b]) begin
                        fwd.byte_valid[b]  = 1'b1;
                        fwd.data[8*b +: 8] = fwd_word[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            pending    <= '0;
            fill_valid <= 1'b0;
            for (int i = 0; i < `SQ_LEN; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].ready <= 1'b0;
            end
        end else begin
            entries    <= next_entries;
            head       <= next_head;
            tail       <= next_tail;
            count      <= next_count;
            pending    <= next_pending;
            fill_valid <= rs_sq.valid;
        end
        fill_idx  <= rs_sq.sq_idx;
        fill_addr <= rs_sq.base + addr_t'(rs_sq.offset);
        fill_data <= rs_sq.data;
    end

    // The reorder buffer never commits more stores than the queue holds
    a_drain_committed: assert property (@(posedge clock) disable iff (reset)
        store_req.valid |-> (pending != '0) && (pending <= count))
        else $error("store drained without a pending commit");

    a_occupancy: assert property (@(posedge clock) disable iff (reset)
        count <= sq_cnt_t'(`SQ_LEN))
        else $error("store queue occupancy above depth");

    // Every older store must have its address before a load issues
    a_load_issue: assert property (@(posedge clock) disable iff (reset)
        load_req.valid |-> load_older <= ready_run)
        else $error("load issued before older store addresses were known");

endmodule

/* data_mem.sv */
`include "lsq_cfg.svh"

module data_mem
    import lsq_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  store_req_t store_req,
    input  addr_t      rd_addr,
    output data_t      rd_data
);

    data_t mem [0:`MEM_WORDS-1];

    logic [`MEM_IDX_BITS-1:0] wr_idx;
    logic [`MEM_IDX_BITS-1:0] rd_idx;

    // Word index, byte offset bits dropped
    assign wr_idx = store_req.addr[`MEM_IDX_BITS+1:2];
    assign rd_idx = rd_addr[`MEM_IDX_BITS+1:2];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int w = 0; w < `MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (store_req.valid) begin
            for (int b = 0; b < 4; b++) begin
                if (store_req.byte_en[b]) begin
                    mem[wr_idx][8*b +: 8] <= store_req.data[8*b +: 8];
                end
            end
        end
    end

    // Asynchronous read, sees the old word during a same-cycle write
    assign rd_data = mem[rd_idx];

    // Drained stores must land inside the array, no aliasing
    a_store_in_range: assert property (@(posedge clock) disable iff (reset)
        store_req.valid |-> store_req.addr[`XLEN-1:`MEM_IDX_BITS+2] == '0)
        else $error("store address beyond memory depth");

endmodule

/* load_merge.sv */
`include "lsq_cfg.svh"

module load_merge
    import lsq_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  load_req_t load_req,
    input  fwd_t      fwd,
    input  data_t     mem_data,
    output load_rsp_t load_rsp
);

    data_t merged;
    data_t shifted;
    data_t result;

    // Forwarded bytes take priority over memory
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            if (fwd.byte_valid[b]) begin
                merged[8*b +: 8] = fwd.data[8*b +: 8];
            end else begin
                merged[8*b +: 8] = mem_data[8*b +: 8];
            end
        end
    end

    // Move the addressed bytes down to bit 0
    assign shifted = merged >> {load_req.addr[1:0], 3'b000};

    always_comb begin
        case (load_req.func[1:0])
            SIZE_BYTE: begin
                if (load_req.func[2]) begin
                    result = {24'h0, shifted[7:0]};
                end else begin
                    result = {{24{shifted[7]}}, shifted[7:0]};
                end
            end
            SIZE_HALF: begin
                if (load_req.func[2]) begin
                    result = {16'h0, shifted[15:0]};
                end else begin
                    result = {{16{shifted[15]}}, shifted[15:0]};
                end
            end
            SIZE_WORD: result = shifted;
            default:   result = shifted;
        endcase
    end

    // Response one cycle after the request
    always_ff @(posedge clock) begin
        if (reset) begin
            load_rsp.valid <= 1'b0;
        end else begin
            load_rsp.valid <= load_req.valid;
        end
        if (load_req.valid) begin
            load_rsp.data <= result;
        end
    end

endmodule

/* lsq_top.sv */
`include "lsq_cfg.svh"

module lsq_top
    import lsq_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  id_sq_t [`N-1:0] id_sq,
    input  rs_sq_t          rs_sq,
    input  sq_cnt_t         commit_count,
    input  load_req_t       load_req,
    output logic            almost_full,
    output sq_idx_t         tail,
    output sq_idx_t         tail_ready,
    output load_rsp_t       load_rsp
);

    // Drain path from the queue into memory
    store_req_t store_req;

    // Both halves of a load, combined in the merge
    fwd_t  fwd;
    data_t rd_data;

    store_queue u_store_queue (
        .clock        (clock),
        .reset        (reset),
        .id_sq        (id_sq),
        .rs_sq        (rs_sq),
        .commit_count (commit_count),
        .load_req     (load_req),
        .almost_full  (almost_full),
        .tail         (tail),
        .tail_ready   (tail_ready),
        .store_req    (store_req),
        .fwd          (fwd)
    );

    data_mem u_data_mem (
        .clock     (clock),
        .reset     (reset),
        .store_req (store_req),
        .rd_addr   (load_req.addr),
        .rd_data   (rd_data)
    );

    load_merge u_load_merge (
        .clock    (clock),
        .reset    (reset),
        .load_req (load_req),
        .fwd      (fwd),
        .mem_data (rd_data),
        .load_rsp (load_rsp)
    );

endmodule

/* tb_lsq.sv */
`include "lsq_cfg.svh"

module tb_lsq
    import lsq_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // 300 random operations at up to 5 cycles each, plus the directed tests
    localparam int RANDOM_OPS = 300;
    localparam int TIMEOUT_CYCLES = RANDOM_OPS * 5 + 500;

    logic            clock = 1'b0;
    logic            reset;
    id_sq_t [`N-1:0] id_sq;
    rs_sq_t          rs_sq;
    sq_cnt_t         commit_count;
    load_req_t       load_req;
    logic            almost_full;
    sq_idx_t         tail;
    sq_idx_t         tail_ready;
    load_rsp_t       load_rsp;

    logic [7:0] model_mem [0:4*`MEM_WORDS-1];
    mem_func_t  slot_func [0:`SQ_LEN-1];
    data_t      exp_q [$];
    int         m_occ;
    int         m_pend;
    sq_idx_t    m_tail;
    logic       rsp_due;
    int         uncommitted = 0;
    int         value_errors = 0;
    int         protocol_errors = 0;
    int         cycles = 0;
    integer     seed;

    lsq_top u_dut (
        .clock        (clock),
        .reset        (reset),
        .id_sq        (id_sq),
        .rs_sq        (rs_sq),
        .commit_count (commit_count),
        .load_req     (load_req),
        .almost_full  (almost_full),
        .tail         (tail),
        .tail_ready   (tail_ready),
        .load_rsp     (load_rsp)
    );

    always #10 clock = ~clock;

    // Expected load value from the program-order byte image
    function automatic data_t ref_load(input addr_t addr, input mem_func_t func);
        data_t value;
        int    nbytes;
        value = '0;
        nbytes = 1 << func[1:0];
        for (int i = 0; i < nbytes; i++) begin
            value[8*i +: 8] = model_mem[addr + i];
        end
        if (!func[2] && nbytes < 4 && value[8*nbytes-1]) begin
            value = value | (32'hffff_ffff << (8*nbytes));
        end
        return value;
    endfunction

    function automatic addr_t rand_addr(input mem_func_t func);
        addr_t a;
        a = addr_t'($unsigned($random(seed)) % 64);
        if (func[1:0] == SIZE_HALF) a[0] = 1'b0;
        if (func[1:0] == SIZE_WORD) a[1:0] = 2'b00;
        return a;
    endfunction

    // Occupancy, tail and pending commits as the queue rules predict them.
    // Only filled, settled stores get committed, so the head is always ready.
    always @(posedge clock) begin
        int drained;
        int allocs;
        if (reset) begin
            m_occ   <= 0;
            m_pend  <= 0;
            m_tail  <= '0;
            rsp_due <= 1'b0;
        end else begin
            drained = (m_pend != 0) ? 1 : 0;
            allocs = 0;
            if (m_occ <= `SQ_LEN - `N) begin
                for (int i = 0; i < `N; i++) begin
                    if (id_sq[i].valid) allocs++;
                end
            end
            m_occ   <= m_occ + allocs - drained;
            m_pend  <= m_pend + int'(commit_count) - drained;
            m_tail  <= m_tail + sq_idx_t'(allocs);
            rsp_due <= load_req.valid;
        end
    end

    // Compare at the falling edge away from the driving edge
    always @(negedge clock) begin
        data_t expected;
        if (!reset) begin
            assert (almost_full == (m_occ > `SQ_LEN - `N)) else begin
                value_errors++;
                $display("Fail at %0t: almost_full %0b at occupancy %0d",
                         $time, almost_full, m_occ);
            end
            assert (tail == m_tail) else begin
                value_errors++;
                $display("Fail at %0t: tail %0d, expected %0d", $time, tail, m_tail);
            end
            if (rsp_due) begin
                expected = exp_q.pop_front();
                assert (load_rsp.valid) else begin
                    protocol_errors++;
                    $display("No load response one cycle after a load, at %0t", $time);
                end
                if (load_rsp.valid) begin
                    assert (load_rsp.data == expected) else begin
                        value_errors++;
                        $display("Fail at %0t: load data %h, expected %h",
                                 $time, load_rsp.data, expected);
                    end
                end
            end else begin
                assert (!load_rsp.valid) else begin
                    protocol_errors++;
                    $display("Load response without a load, at %0t", $time);
                end
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic dispatch(input int n, input mem_func_t func, output sq_idx_t first);
        first = m_tail;
        for (int i = 0; i < n; i++) begin
            id_sq[i].valid = 1'b1;
            id_sq[i].func  = func;
            if (m_occ <= `SQ_LEN - `N) slot_func[first + sq_idx_t'(i)] = func;
        end
        next_cycle();
        id_sq = '0;
    endtask

    // Address goes in as base plus a random offset
    task automatic fill(input sq_idx_t idx, input addr_t addr, input data_t data);
        logic [11:0] offset;
        int          nbytes;
        nbytes = 1 << slot_func[idx][1:0];
        for (int i = 0; i < nbytes; i++) begin
            model_mem[addr + i] = data[8*i +: 8];
        end
        offset = 12'($unsigned($random(seed)) % 256);
        rs_sq.valid  = 1'b1;
        rs_sq.base   = addr - addr_t'(offset);
        rs_sq.offset = offset;
        rs_sq.data   = data;
        rs_sq.sq_idx = idx;
        next_cycle();
        rs_sq.valid = 1'b0;
    endtask

    // Ready lands on the second edge after the strobe
    task automatic settle();
        next_cycle();
        assert (tail_ready == m_tail) else begin
            value_errors++;
            $display("Fail at %0t: tail_ready %0d, expected %0d", $time, tail_ready, m_tail);
        end
    endtask

    task automatic do_store(input addr_t addr, input data_t data, input mem_func_t func);
        sq_idx_t idx;
        dispatch(1, func, idx);
        fill(idx, addr, data);
        // The new store waits in the fill register and ends the ready run
        assert (tail_ready == idx) else begin
            value_errors++;
            $display("Fail at %0t: tail_ready %0d before the fill lands, expected %0d",
                     $time, tail_ready, idx);
        end
        settle();
        uncommitted++;
    endtask

    task automatic commit(input int n);
        commit_count = sq_cnt_t'(n);
        uncommitted -= n;
        next_cycle();
        commit_count = '0;
    endtask

    task automatic drain_all();
        while (uncommitted > 0) commit((uncommitted > `N) ? `N : uncommitted);
        while (m_occ != 0) next_cycle();
    endtask

    task automatic issue_load(input addr_t addr, input mem_func_t func);
        exp_q.push_back(ref_load(addr, func));
        load_req.valid      = 1'b1;
        load_req.addr       = addr;
        load_req.func       = func;
        load_req.tail_store = m_tail;
        next_cycle();
        load_req.valid = 1'b0;
    endtask

    initial begin
        int        op;
        int        n;
        mem_func_t func;
        sq_idx_t   first;
        sq_idx_t   idx;
        seed = 51;
        reset = 1'b1;
        id_sq = '0;
        rs_sq = '0;
        commit_count = '0;
        load_req = '0;
        for (int i = 0; i < 4*`MEM_WORDS; i++) model_mem[i] = 8'h00;
        repeat (3) @(posedge clock);
        #2;
        reset = 1'b0;
        assert (!almost_full && tail == '0 && tail_ready == '0 && !load_rsp.valid) else begin
            value_errors++;
            $display("Fail at %0t: outputs not idle after reset", $time);
        end

        // Forwarding from a store that is still uncommitted
        do_store(32'h10, 32'h8bad_f00d, 3'b010);
        issue_load(32'h10, 3'b010);
        issue_load(32'h13, 3'b000);
        issue_load(32'h12, 3'b101);
        drain_all();

        // Byte from the queue merged with memory
        do_store(32'h11, 32'h0000_005a, 3'b000);
        issue_load(32'h10, 3'b010);
        issue_load(32'h11, 3'b100);
        drain_all();

        do_store(32'h20, 32'h0000_8001, 3'b001);
        do_store(32'h23, 32'h0000_00f0, 3'b000);
        do_store(32'h24, 32'h7fff_8080, 3'b010);
        drain_all();
        issue_load(32'h20, 3'b001);
        issue_load(32'h20, 3'b101);
        issue_load(32'h23, 3'b000);
        issue_load(32'h23, 3'b100);
        issue_load(32'h24, 3'b010);
        issue_load(32'h24, 3'b001);
        issue_load(32'h26, 3'b001);

        // Fill up until almost_full and then one dispatch that must be ignored
        first = m_tail;
        while (m_occ <= `SQ_LEN - `N) dispatch(`N, 3'b010, idx);
        dispatch(`N, 3'b010, idx);
        assert (tail == idx) else begin
            value_errors++;
            $display("Fail at %0t: tail moved to %0d while almost_full", $time, tail);
        end
        n = m_occ;
        for (int i = 0; i < n; i++) begin
            fill(first + sq_idx_t'(i), addr_t'(32'h40 + 4*i), data_t'($random(seed)));
        end
        settle();
        uncommitted += n;
        drain_all();
        issue_load(32'h44, 3'b010);

        for (int k = 0; k < RANDOM_OPS; k++) begin
            op = $unsigned($random(seed)) % 4;
            if (op < 2 && m_occ < `SQ_LEN - `N) begin
                func = mem_func_t'($unsigned($random(seed)) % 3);
                do_store(rand_addr(func), data_t'($random(seed)), func);
            end else if (op < 3 && uncommitted > 0) begin
                n = 1 + $unsigned($random(seed)) % `N;
                commit((n > uncommitted) ? uncommitted : n);
            end else if (op == 3) begin
                func = mem_func_t'($unsigned($random(seed)) % 6);
                if (func == 3'b011) func = 3'b010;
                issue_load(rand_addr(func), func);
            end else begin
                next_cycle();
            end
        end
        drain_all();
        repeat (2) next_cycle();

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+.
lsq_pkg.sv
store_queue.sv
data_mem.sv
load_merge.sv
lsq_top.sv
tb_lsq.sv

/* Makefile */
.PHONY: all lint clean

all: obj_dir/Vtb_lsq
	./obj_dir/Vtb_lsq > sim.log 2>&1; cat sim.log
	grep -q -F '*** PASSED ***' sim.log

obj_dir/Vtb_lsq: src.f lsq_cfg.svh lsq_pkg.sv store_queue.sv data_mem.sv load_merge.sv lsq_top.sv tb_lsq.sv
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_lsq -f src.f

lint:
	verilator --lint-only -Wall --timing --top-module tb_lsq -f src.f

clean:
	rm -rf obj_dir sim.log
